//--- rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h1eceb000

// packet slots in the fetch queue
`define FETCH_QUEUE_DEPTH 8

// direct-mapped lines of 32 bytes each
`define ICACHE_SETS 16

// 64-bit beats per 256-bit line
`define BMEM_BEATS 4

`endif

//--- rtl/fetch_pkg.sv
package fetch_pkg;

    // one fetched instruction and the address it came from
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_pkt_t;

    // request from pc_gen to the icache
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;  // word aligned byte address
    } fetch_req_t;

endpackage : fetch_pkg

//--- rtl/pc_gen.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module pc_gen
import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,

    input  logic        resp_i,
    input  logic        has_room_i,

    output fetch_req_t  req_o,
    output logic        enq_o
);

    logic [31:0] pc_q;      // next address to fetch
    logic        pending_q; // a request is in the icache
    logic        stale_q;   // the pending request predates a redirect
    logic        issue;

    // at most one request in flight and the next one may leave with the previous resp
    assign issue = !redirect_i && (!pending_q || resp_i) && has_room_i;

    assign req_o.valid = issue;
    assign req_o.addr  = pc_q;

    // responses from before a redirect never reach the queue
    assign enq_o = resp_i && !stale_q && !redirect_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= `FETCH_RESET_PC;
            pending_q <= 1'b0;
            stale_q   <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (issue) begin
                pc_q <= pc_q + 32'd4;   // sequential fetch
            end

            if (issue) begin
                pending_q <= 1'b1;
            end else if (resp_i) begin
                pending_q <= 1'b0;
            end

            if (redirect_i && pending_q && !resp_i) begin
                stale_q <= 1'b1;    // drop the result of the miss still running
            end else if (resp_i) begin
                stale_q <= 1'b0;
            end
        end
    end

endmodule : pc_gen

//--- rtl/cacheline_adapter.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module cacheline_adapter (
    input  logic         clk,
    input  logic         rst,

    input  logic [63:0]  bmem_rdata_i,
    input  logic         bmem_rvalid_i,

    output logic [255:0] line_o,
    output logic         line_valid_o
);

    localparam int BEAT_W = $clog2(`BMEM_BEATS);

    logic [255:0]      line_q;
    logic [BEAT_W-1:0] beat_q;
    logic              last_beat;

    assign last_beat = bmem_rvalid_i && (beat_q == BEAT_W'(`BMEM_BEATS - 1));

    // first beat ends up in the low bits of the line
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[255:64]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q       <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat;  // one cycle after the final beat
            if (last_beat) begin
                beat_q <= '0;
            end else if (bmem_rvalid_i) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    assign line_o = line_q;

endmodule : cacheline_adapter

//--- rtl/icache.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module icache
import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  fetch_req_t   req_i,
    output logic         resp_o,
    output fetch_pkt_t   pkt_o,

    output logic [31:0]  bmem_addr_o,
    output logic         bmem_read_o,
    input  logic         bmem_ready_i,

    input  logic [255:0] line_i,
    input  logic         line_valid_i
);

    localparam int IDX_W = $clog2(`ICACHE_SETS);
    localparam int TAG_W = 32 - IDX_W - 5;

    typedef enum logic [2:0] {
        S_IDLE,
        S_COMPARE,
        S_ISSUE,
        S_FILL,
        S_RESPOND
    } state_t;

    state_t state_q, state_d;

    logic [TAG_W-1:0]        tag_arr  [`ICACHE_SETS];
    logic [255:0]            data_arr [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_q;

    logic [31:0]      addr_q;   // address of the request being served
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [2:0]       word_sel;
    logic [255:0]     line_rd;
    logic             hit;
    logic             fill;
    logic             accept;

    assign idx      = addr_q[5 +: IDX_W];
    assign tag      = addr_q[31 -: TAG_W];
    assign word_sel = addr_q[4:2];
    assign line_rd  = data_arr[idx];
    assign hit      = valid_q[idx] && (tag_arr[idx] == tag);
    assign fill     = (state_q == S_FILL) && line_valid_i;

    assign resp_o     = ((state_q == S_COMPARE) && hit) || (state_q == S_RESPOND);
    assign pkt_o.pc   = addr_q;
    assign pkt_o.inst = line_rd[{word_sel, 5'b0} +: 32];

    // a new request may arrive in the same cycle as a response
    assign accept = req_i.valid && ((state_q == S_IDLE) || resp_o);

    assign bmem_addr_o = {addr_q[31:5], 5'b0};
    assign bmem_read_o = (state_q == S_ISSUE) && bmem_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_i.valid) state_d = S_COMPARE;
            end
            S_COMPARE: begin
                if (!hit) begin
                    state_d = S_ISSUE;
                end else if (!req_i.valid) begin
                    state_d = S_IDLE;
                end
            end
            S_ISSUE: begin
                if (bmem_ready_i) state_d = S_FILL;   // read pulse goes out here
            end
            S_FILL: begin
                if (line_valid_i) state_d = S_RESPOND;
            end
            S_RESPOND: begin
                state_d = req_i.valid ? S_COMPARE : S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill) valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_i.addr;
        end
        if (fill) begin
            tag_arr[idx]  <= tag;
            data_arr[idx] <= line_i;
        end
    end

endmodule : icache

//--- rtl/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_queue
import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       flush_i,

    input  logic       enq_i,
    input  fetch_pkt_t enq_pkt_i,

    input  logic       deq_i,

    output fetch_pkt_t head_o,
    output logic       empty_o,
    output logic       has_room_o
);

    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_pkt_t       mem [DEPTH];
    logic [PTR_W-1:0] head_q, tail_q;
    logic [CNT_W-1:0] count_q;
    logic             do_enq, do_deq;

    assign empty_o = (count_q == '0);
    assign do_enq  = enq_i && !flush_i && (count_q != CNT_W'(DEPTH));
    assign do_deq  = deq_i && !flush_i && !empty_o;

    // room left after this cycle's enqueue with no credit for a dequeue
    assign has_room_o = (count_q + CNT_W'(enq_i)) < CNT_W'(DEPTH);

    assign head_o = mem[head_q];

    always_ff @(posedge clk) begin
        if (do_enq) mem[tail_q] <= enq_pkt_i;
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_enq) tail_q <= tail_q + 1'b1;
            if (do_deq) head_q <= head_q + 1'b1;
            if (do_enq && !do_deq) begin
                count_q <= count_q + 1'b1;
            end else if (do_deq && !do_enq) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule : fetch_queue

//--- rtl/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend
import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    output logic [31:0] bmem_addr_o,
    output logic        bmem_read_o,
    input  logic        bmem_ready_i,

    input  logic [31:0] bmem_raddr_i,   // unused since beats arrive in order
    input  logic [63:0] bmem_rdata_i,
    input  logic        bmem_rvalid_i,

    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,

    input  logic        deq_i,
    output fetch_pkt_t  inst_pkt_o,
    output logic        empty_o
);

    fetch_req_t   req;
    fetch_pkt_t   pkt;
    logic         resp;
    logic         enq;
    logic         has_room;
    logic [255:0] line;
    logic         line_valid;

    pc_gen u_pc_gen (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .resp_i        (resp),
        .has_room_i    (has_room),
        .req_o         (req),
        .enq_o         (enq)
    );

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .resp_o       (resp),
        .pkt_o        (pkt),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_ready_i (bmem_ready_i),
        .line_i       (line),
        .line_valid_i (line_valid)
    );

    cacheline_adapter u_cacheline_adapter (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (line),
        .line_valid_o  (line_valid)
    );

    // redirect empties the queue in the same cycle
    fetch_queue u_fetch_queue (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (redirect_i),
        .enq_i      (enq),
        .enq_pkt_i  (pkt),
        .deq_i      (deq_i),
        .head_o     (inst_pkt_o),
        .empty_o    (empty_o),
        .has_room_o (has_room)
    );

endmodule : fetch_frontend

//--- verif/bmem_model.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module bmem_model (
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] addr_i,
    input  logic        read_i,
    output logic        ready_o,

    output logic [31:0] raddr_o,
    output logic [63:0] rdata_o,
    output logic        rvalid_o,

    output logic [31:0] read_count_o
);

    integer seed = 32'h3daf_9303;

    // every word holds its byte address with a fixed pattern mixed in
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0] line_addr;
        logic [31:0] beat_addr;
        int          delay;
        int          gap;

        ready_o      = 1'b1;
        rvalid_o     = 1'b0;
        raddr_o      = '0;
        rdata_o      = '0;
        read_count_o = '0;
        forever begin
            @(negedge clk);  // read pulse is stable here
            if (!rst && read_i) begin
                read_count_o = read_count_o + 32'd1;
                line_addr    = addr_i;
                next_cycle();
                ready_o = 1'b0;
                delay   = $random(seed) & 32'h7;
                repeat (delay) next_cycle();
                for (int beat = 0; beat < `BMEM_BEATS; beat++) begin
                    gap = $random(seed) & 32'h3;
                    repeat (gap) next_cycle();  // idle cycles between beats
                    beat_addr = line_addr + 32'(beat * 8);
                    raddr_o   = line_addr;
                    rdata_o   = {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
                    rvalid_o  = 1'b1;
                    next_cycle();
                    rvalid_o  = 1'b0;
                end
                ready_o = 1'b1;
            end
        end
    end

endmodule : bmem_model

//--- verif/fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions (
    input logic clk,
    input logic rst,
    input logic bmem_read_i,
    input logic bmem_ready_i,
    input logic redirect_i,
    input logic empty_i
);

    int unsigned pulse_fails = 0;
    int unsigned ready_fails = 0;
    int unsigned flush_fails = 0;
    int unsigned fail_count;

    assign fail_count = pulse_fails + ready_fails + flush_fails;

    read_is_pulse: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |=> !bmem_read_i)
        else begin
            $error("bmem_read held high for more than one cycle");
            pulse_fails++;
        end

    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_ready_i)
        else begin
            $error("bmem_read raised while bmem_ready is low");
            ready_fails++;
        end

    // the queue flush lands at the redirect edge
    flush_empties: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> empty_i)
        else begin
            $error("fetch queue not empty after a redirect");
            flush_fails++;
        end

endmodule : fetch_assertions

bind fetch_frontend fetch_assertions u_fetch_assertions (
    .clk          (clk),
    .rst          (rst),
    .bmem_read_i  (bmem_read_o),
    .bmem_ready_i (bmem_ready_i),
    .redirect_i   (redirect_i),
    .empty_i      (empty_o)
);

//--- verif/tb_fetch_frontend.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_fetch_frontend
import fetch_pkg::*;
();

    logic        clk;
    logic        rst;
    logic [31:0] bmem_addr;
    logic        bmem_read;
    logic        bmem_ready;
    logic [31:0] bmem_raddr;
    logic [63:0] bmem_rdata;
    logic        bmem_rvalid;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        deq = 1'b0;
    fetch_pkt_t  inst_pkt;
    logic        empty;
    logic [31:0] read_count;

    integer      seed = 32'h3daf_9303;
    int          deq_mode = 0;                      // 0 hold, 1 random strobes
    logic [31:0] expected_pc = `FETCH_RESET_PC;
    int          checked = 0;
    int          errors = 0;                        // packet compare errors
    int          main_errors = 0;                   // sequence level errors
    bit          timed_out = 1'b0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    fetch_frontend u_fetch_frontend (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .deq_i         (deq),
        .inst_pkt_o    (inst_pkt),
        .empty_o       (empty)
    );

    bmem_model u_bmem_model (
        .clk          (clk),
        .rst          (rst),
        .addr_i       (bmem_addr),
        .read_i       (bmem_read),
        .ready_o      (bmem_ready),
        .raddr_o      (bmem_raddr),
        .rdata_o      (bmem_rdata),
        .rvalid_o     (bmem_rvalid),
        .read_count_o (read_count)
    );

    function automatic logic [31:0] expected_inst(input logic [31:0] pc);
        return pc ^ 32'h5a5a_0000;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAILED");
        timed_out = 1'b1;
    endtask

    task automatic wait_checked(input int count, input int limit);
        int target;
        int cycles;

        target = checked + count;
        cycles = 0;
        while (!timed_out && checked < target && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (!timed_out && checked < target) report_timeout("dequeued packets");
    endtask

    task automatic pulse_redirect(input logic [31:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        next_cycle();
        redirect    = 1'b0;
    endtask

    always @(posedge clk) begin
        #1;
        if (deq_mode == 1) deq = ($random(seed) % 2) != 0;
        else deq = 1'b0;
    end

    // head is stable at the falling edge and the dequeue happens at the next rising one
    always @(negedge clk) begin
        if (!rst) begin
            if (redirect) begin
                expected_pc = redirect_pc;  // flush wins over the dequeue
            end else if (deq && !empty) begin
                if (inst_pkt.pc !== expected_pc) begin
                    $display("[FAIL] inst_pkt_o.pc = %h, expected %h", inst_pkt.pc, expected_pc);
                    errors++;
                end
                if (inst_pkt.inst !== expected_inst(expected_pc)) begin
                    $display("[FAIL] inst_pkt_o.inst = %h, expected %h",
                             inst_pkt.inst, expected_inst(expected_pc));
                    errors++;
                end
                expected_pc = expected_pc + 32'd4;
                checked++;
            end
        end
    end

    initial begin
        logic [31:0] base_reads;
        int          cycles;
        int          assert_fails;

        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        repeat (4) begin
            next_cycle();
            if (empty !== 1'b1) begin
                $display("[FAIL] empty_o = %h, expected %h", empty, 1'b1);
                main_errors++;
            end
            if (bmem_read !== 1'b0) begin
                $display("[FAIL] bmem_read_o = %h, expected %h", bmem_read, 1'b0);
                main_errors++;
            end
        end
        rst = 1'b0;

        cycles = 0;
        while (empty && cycles < 200) begin
            next_cycle();
            cycles++;
        end
        if (empty) begin
            report_timeout("the first packet");
        end else if (inst_pkt.pc !== `FETCH_RESET_PC) begin
            $display("[FAIL] inst_pkt_o.pc = %h, expected %h", inst_pkt.pc, `FETCH_RESET_PC);
            main_errors++;
        end

        deq_mode = 1;  // sequential stream
        wait_checked(64, 3000);

        deq_mode = 0;  // no dequeue until the queue fills and fetch stops
        repeat (100) next_cycle();
        base_reads = read_count;
        repeat (100) begin
            next_cycle();
            if (empty !== 1'b0) begin
                $display("[FAIL] empty_o = %h, expected %h", empty, 1'b0);
                main_errors++;
            end
        end
        if (read_count !== base_reads) begin
            $display("[FAIL] read_count = %h, expected %h", read_count, base_reads);
            main_errors++;
        end
        deq_mode = 1;
        wait_checked(24, 3000);

        cycles = 0;
        while (!timed_out && bmem_ready && cycles < 500) begin
            next_cycle();
            cycles++;
        end
        if (!timed_out && bmem_ready) report_timeout("a line fill");
        pulse_redirect(32'h0004_1a4c);  // lands in the middle of a miss
        wait_checked(16, 3000);

        deq_mode = 0;
        repeat (100) next_cycle();
        pulse_redirect(32'h0123_0100);  // queue full
        deq_mode = 1;
        wait_checked(40, 4000);

        // lines from 0x0123_0100 on are still cached
        deq_mode = 0;
        repeat (100) next_cycle();
        base_reads = read_count;
        pulse_redirect(32'h0123_0100);
        deq_mode = 1;
        wait_checked(8, 1000);
        if (read_count !== base_reads) begin
            $display("[FAIL] read_count = %h, expected %h", read_count, base_reads);
            main_errors++;
        end

        deq_mode = 0;
        repeat (5) next_cycle();
        assert_fails = u_fetch_frontend.u_fetch_assertions.fail_count;
        $display("errors: %0d packet, %0d sequence, %0d assertion (%0d packets checked)",
                 errors, main_errors, assert_fails, checked);
        if (!timed_out) begin
            if (errors + main_errors + assert_fails == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule : tb_fetch_frontend

//--- src.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/cacheline_adapter.sv
rtl/icache.sv
rtl/fetch_queue.sv
rtl/fetch_frontend.sv
verif/bmem_model.sv
verif/fetch_assertions.sv
verif/tb_fetch_frontend.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fetch_frontend
FILELIST  := src.f
OBJDIR    := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not finish"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
